/* Makefile */
TOP = memSubsystemTb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module $(TOP) -f list.f

obj_dir/simv: list.f $(wildcard common/* memCtrl/*.sv verilog/*.sv test/*.sv)
	verilator --binary --assert --top-module $(TOP) -f list.f -o simv

sim: obj_dir/simv
	./obj_dir/simv | tee sim.log
	grep -q "=== PASS ===" sim.log

clean:
	rm -rf obj_dir sim.log

/* common/memCtrl_consts.svh */
`ifndef MEMCTRL_CONSTS_SVH
`define MEMCTRL_CONSTS_SVH

// address and data widths
`define MEM_ADDR_W 17
`define MEM_WORD_W 32

// byte RAM depth
`define MEM_BYTES (1 << `MEM_ADDR_W)

// access length field, in bytes
`define MEM_LEN_W 3
`define LEN_BYTE 3'd1
`define LEN_HALF 3'd2
`define LEN_WORD 3'd4

`endif

/* common/memIf.sv */
`timescale 1ns/1ps

`include "memCtrl_consts.svh"

// one client's request channel into the controller
interface memReqIf;
    logic                    en;
    memPkg::accessKind       kind;
    logic [`MEM_LEN_W-1:0]   len;
    logic [`MEM_ADDR_W-1:0]  addr;
    logic [`MEM_WORD_W-1:0]  wdata;
    logic                    done;
    logic [`MEM_WORD_W-1:0]  rdata;

    modport client (
        output en, kind, len, addr, wdata,
        input  done, rdata
    );

    modport ctrl (
        input  en, kind, len, addr, wdata,
        output done, rdata
    );
endinterface

// byte-wide RAM port
interface ramBusIf;
    logic                    we;
    logic [`MEM_ADDR_W-1:0]  addr;
    logic [7:0]              wdata;
    logic [7:0]              rdata;

    modport ctrl (
        output we, addr, wdata,
        input  rdata
    );

    modport ram (
        input  we, addr, wdata,
        output rdata
    );
endinterface

/* common/memPkg.sv */
package memPkg;

    // controller main state
    typedef enum logic [1:0] {
        ST_IDLE  = 2'd0,
        ST_FETCH = 2'd1,
        ST_LOAD  = 2'd2,
        ST_STORE = 2'd3
    } ctrlState;

    // data client operation
    typedef enum logic {
        ACC_LOAD  = 1'b0,
        ACC_STORE = 1'b1
    } accessKind;

endpackage

/* list.f */
+incdir+common
common/memPkg.sv
common/memIf.sv
memCtrl/memCtrl.sv
verilog/byteRam.sv
verilog/memSubsystem.sv
test/memSubsystem_assert.sv
test/memSubsystemTb.sv

/* memCtrl/memCtrl.sv */
`timescale 1ns/1ps

`include "memCtrl_consts.svh"

module memCtrl (
    input  logic  clk,
    input  logic  rst,
    input  logic  rdy,
    input  logic  ioBufferFull,
    memReqIf.ctrl fetchBus,
    memReqIf.ctrl dataBus,
    ramBusIf.ctrl ram,
    output logic  busy
);

    memPkg::ctrlState state;
    logic [2:0] stage;

    logic [`MEM_ADDR_W-1:0] addrReg;
    logic [`MEM_LEN_W-1:0]  lenReg;
    logic [`MEM_WORD_W-1:0] wdataReg;
    logic [`MEM_WORD_W-1:0] asmWord;

    logic fetchDoneQ;
    logic dataDoneQ;

    logic       stall;
    logic       fetchReq;
    logic       dataReq;
    logic [2:0] ofs;
    logic [2:0] lane;
    logic       lastStore;
    logic       lastRead;

    assign stall = !rdy || ioBufferFull;

    // a client still holding en in its done cycle is not a new request
    assign dataReq  = dataBus.en && !dataDoneQ;
    assign fetchReq = fetchBus.en && !fetchDoneQ;

    assign lastStore = (stage == lenReg - 3'd1);
    // reads need one extra stage for the last byte to come back
    assign lastRead  = (stage == lenReg);
    assign lane      = stage - 3'd1;

    // while frozen re-present the previous byte address so that the
    // pending read byte is still on rdata when the stall ends
    assign ofs = stall ? stage - 3'd1 : stage;

    assign ram.addr  = addrReg + `MEM_ADDR_W'(ofs);
    assign ram.we    = (state == memPkg::ST_STORE) && !stall;
    assign ram.wdata = wdataReg[{stage[1:0], 3'b000} +: 8];

    assign busy = (state != memPkg::ST_IDLE);

    assign fetchBus.done  = fetchDoneQ;
    assign fetchBus.rdata = asmWord;
    assign dataBus.done   = dataDoneQ;
    assign dataBus.rdata  = asmWord;

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= memPkg::ST_IDLE;
            stage      <= '0;
            fetchDoneQ <= 1'b0;
            dataDoneQ  <= 1'b0;
        end else begin
            // done is a single pulse, so it never holds through a stall
            fetchDoneQ <= 1'b0;
            dataDoneQ  <= 1'b0;
            if (!stall) begin
                case (state)
                    memPkg::ST_IDLE: begin
                        stage <= '0;
                        if (dataReq) begin
                            if (dataBus.kind == memPkg::ACC_STORE) begin
                                state <= memPkg::ST_STORE;
                            end else begin
                                state <= memPkg::ST_LOAD;
                            end
                        end else if (fetchReq) begin
                            state <= memPkg::ST_FETCH;
                        end
                    end
                    memPkg::ST_STORE: begin
                        if (lastStore) begin
                            state     <= memPkg::ST_IDLE;
                            stage     <= '0;
                            dataDoneQ <= 1'b1;
                        end else begin
                            stage <= stage + 3'd1;
                        end
                    end
                    default: begin
                        if (lastRead) begin
                            state <= memPkg::ST_IDLE;
                            stage <= '0;
                            if (state == memPkg::ST_FETCH) begin
                                fetchDoneQ <= 1'b1;
                            end else begin
                                dataDoneQ <= 1'b1;
                            end
                        end else begin
                            stage <= stage + 3'd1;
                        end
                    end
                endcase
            end
        end
    end

    // request payload and word assembly
    always_ff @(posedge clk) begin
        if (!stall) begin
            if (state == memPkg::ST_IDLE) begin
                asmWord <= '0;
                if (dataReq) begin
                    addrReg  <= dataBus.addr;
                    lenReg   <= dataBus.len;
                    wdataReg <= dataBus.wdata;
                end else if (fetchReq) begin
                    addrReg  <= fetchBus.addr;
                    lenReg   <= fetchBus.len;
                    wdataReg <= fetchBus.wdata;
                end
            end else if (state != memPkg::ST_STORE && stage != 3'd0) begin
                // byte for stage-1 arrives now
                asmWord[{lane[1:0], 3'b000} +: 8] <= ram.rdata;
            end
        end
    end

endmodule

/* test/memSubsystemTb.sv */
`timescale 1ns/1ps

`include "memCtrl_consts.svh"

module memSubsystemTb;

    localparam int PERIOD       = 20;
    localparam int RESET_CYCLES = 3;
    localparam int OP_LIMIT     = 100;
    localparam int STIM_MAX     = 64;
    // four bytes plus two cycles of read turnaround
    localparam int FETCH_LAT    = 6;

    logic                   clk;
    logic                   rst;
    logic                   rdy;
    logic                   ioBufferFull;
    logic                   fetchEn;
    logic [`MEM_ADDR_W-1:0] fetchAddr;
    logic                   fetchDone;
    logic [`MEM_WORD_W-1:0] fetchInst;
    logic                   dataEn;
    memPkg::accessKind      dataKind;
    logic [`MEM_LEN_W-1:0]  dataLen;
    logic [`MEM_ADDR_W-1:0] dataAddr;
    logic [`MEM_WORD_W-1:0] dataWdata;
    logic                   dataDone;
    logic [`MEM_WORD_W-1:0] dataRdata;
    logic                   busy;

    // five words per operation, see the stimulus file
    logic [31:0] stim [STIM_MAX * 5];
    logic [7:0]  model [int];
    int          opCount;
    int          errors;
    bit          stallOn;

    memSubsystem dut0 (
        .clk          (clk),
        .rst          (rst),
        .rdy          (rdy),
        .ioBufferFull (ioBufferFull),
        .fetchEn      (fetchEn),
        .fetchAddr    (fetchAddr),
        .fetchDone    (fetchDone),
        .fetchInst    (fetchInst),
        .dataEn       (dataEn),
        .dataKind     (dataKind),
        .dataLen      (dataLen),
        .dataAddr     (dataAddr),
        .dataWdata    (dataWdata),
        .dataDone     (dataDone),
        .dataRdata    (dataRdata),
        .busy         (busy)
    );

    always #(PERIOD / 2) clk = ~clk;

    task automatic checkValue(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            $display("MISMATCH %s exp=%h act=%h", name, exp, act);
            errors++;
        end
    endtask

    // little-endian word from the byte model, zero above n bytes
    function automatic logic [31:0] modelWord(input logic [`MEM_ADDR_W-1:0] addr, input int n);
        logic [31:0] w;
        int          key;
        w = '0;
        for (int i = 0; i < n; i++) begin
            key = int'(addr + `MEM_ADDR_W'(i));
            if (model.exists(key)) begin
                w[8*i +: 8] = model[key];
            end
        end
        return w;
    endfunction

    // random freeze for the coming cycle
    task automatic stallTick();
        rdy = 1'b1;
        ioBufferFull = 1'b0;
        if (stallOn && ($urandom % 3 == 0)) begin
            if ($urandom % 2 == 0) begin
                rdy = 1'b0;
            end else begin
                ioBufferFull = 1'b1;
            end
        end
    endtask

    task automatic waitDone(input bit forFetch, input int expLat, output bit got, output int cycles);
        string name;
        logic  other;
        name = forFetch ? "fetchDone" : "dataDone";
        got = 1'b0;
        cycles = 0;
        while (!got && cycles < OP_LIMIT) begin
            @(negedge clk);
            cycles++;
            got = forFetch ? fetchDone : dataDone;
            other = forFetch ? dataDone : fetchDone;
            if (other) begin
                $display("done pulse from the wrong client while waiting for %s", name);
                errors++;
            end
            // busy from the cycle after sampling up to the done cycle
            if (!stallOn) begin
                checkValue("busy", 32'(cycles < expLat), 32'(busy));
            end
            stallTick();
        end
        if (!got) begin
            $display("no %s within %0d cycles", name, OP_LIMIT);
            errors++;
        end
    endtask

    // kind 0 load, 1 store, 2 fetch, 3 load together with a fetch
    task automatic runOp(input logic [31:0] kind, addr, len, wdata, expWord);
        bit got;
        int cycles;
        int n;
        int lat;
        n = int'(len[2:0]);
        lat = n + ((kind == 1) ? 1 : 2);
        @(negedge clk);
        stallOn = ($urandom % 2 == 1);
        repeat (stallOn ? 2 : 0) begin
            stallTick();
            @(negedge clk);
        end
        rdy = 1'b1;
        ioBufferFull = 1'b0;
        if (kind != 2) begin
            dataEn = 1'b1;
            dataKind = memPkg::ACC_LOAD;
            if (kind == 1) begin
                dataKind = memPkg::ACC_STORE;
            end
            dataLen = len[2:0];
            dataAddr = addr[`MEM_ADDR_W-1:0];
            dataWdata = wdata;
        end
        if (kind >= 2) begin
            fetchEn = 1'b1;
            fetchAddr = (kind == 3) ? wdata[`MEM_ADDR_W-1:0] : addr[`MEM_ADDR_W-1:0];
        end
        if (kind != 2) begin
            waitDone(1'b0, lat, got, cycles);
            dataEn = 1'b0;
            if (got && kind == 1) begin
                for (int i = 0; i < n; i++) begin
                    model[int'(addr[`MEM_ADDR_W-1:0] + `MEM_ADDR_W'(i))] = wdata[8*i +: 8];
                end
            end else if (got) begin
                checkValue("dataRdata", expWord, dataRdata);
                checkValue("dataRdata (byte model)", modelWord(dataAddr, n), dataRdata);
            end
            if (got && !stallOn) begin
                checkValue("dataDone latency", 32'(lat), 32'(cycles));
            end
        end
        if (kind >= 2) begin
            // a pending fetch is sampled in the idle cycle of dataDone
            waitDone(1'b1, FETCH_LAT, got, cycles);
            fetchEn = 1'b0;
            if (got) begin
                checkValue("fetchInst (byte model)", modelWord(fetchAddr, 4), fetchInst);
                if (kind == 2) begin
                    checkValue("fetchInst", expWord, fetchInst);
                end
            end
            if (got && !stallOn) begin
                checkValue("fetchDone latency", 32'(FETCH_LAT), 32'(cycles));
            end
        end
    endtask

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        rdy = 1'b1;
        ioBufferFull = 1'b0;
        fetchEn = 1'b0;
        fetchAddr = '0;
        dataEn = 1'b0;
        dataKind = memPkg::ACC_LOAD;
        dataLen = '0;
        dataAddr = '0;
        dataWdata = '0;
        stallOn = 1'b0;
        errors = 0;
        opCount = 0;
        void'($urandom(32'hf680));
        // unread entries carry an invalid kind
        for (int j = 0; j < STIM_MAX * 5; j++) begin
            stim[j] = {16'hffff, 16'(j)};
        end
        $readmemh("test/memSubsystem_stimulus.txt", stim);
        while (opCount < STIM_MAX && stim[opCount * 5] <= 32'd3) begin
            opCount++;
        end
        if (opCount == 0) begin
            $display("no operations read from the stimulus file");
            errors++;
        end
        repeat (RESET_CYCLES) @(negedge clk);
        checkValue("fetchDone", 32'd0, 32'(fetchDone));
        checkValue("dataDone", 32'd0, 32'(dataDone));
        checkValue("busy", 32'd0, 32'(busy));
        rst = 1'b0;
        for (int i = 0; i < opCount; i++) begin
            runOp(stim[i*5], stim[i*5+1], stim[i*5+2], stim[i*5+3], stim[i*5+4]);
        end
        @(negedge clk);
        $display("closing: %0d errors over %0d operations", errors, opCount);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    initial begin
        // the operation count is final once reset is released
        @(negedge rst);
        #((opCount * OP_LIMIT + RESET_CYCLES) * PERIOD);
        $display("watchdog expired before all operations finished");
        $display("=== FAIL ===");
        $finish;
    end

endmodule

/* test/memSubsystem_assert.sv */
`timescale 1ns/1ps

module memSubsystemAssert (
    input logic             clk,
    input logic             rst,
    input logic             rdy,
    input logic             ioBufferFull,
    input logic             fetchDone,
    input logic             dataDone,
    input logic             we,
    input memPkg::ctrlState state
);

    logic stall;

    assign stall = !rdy || ioBufferFull;

    fetchDonePulse: assert property (@(posedge clk) disable iff (rst) fetchDone |=> !fetchDone)
        else $error("fetchDone high for more than one cycle");

    dataDonePulse: assert property (@(posedge clk) disable iff (rst) dataDone |=> !dataDone)
        else $error("dataDone high for more than one cycle");

    // only one client owns the controller at a time
    doneExclusive: assert property (@(posedge clk) disable iff (rst) !(fetchDone && dataDone))
        else $error("fetchDone and dataDone in the same cycle");

    noWriteWhenStalled: assert property (@(posedge clk) disable iff (rst) stall |-> !we)
        else $error("RAM write enable high in a stalled cycle");

    stateFrozen: assert property (@(posedge clk) disable iff (rst) stall |=> $stable(state))
        else $error("controller state moved in a stalled cycle");

endmodule

bind memCtrl memSubsystemAssert assert0 (
    .clk          (clk),
    .rst          (rst),
    .rdy          (rdy),
    .ioBufferFull (ioBufferFull),
    .fetchDone    (fetchDoneQ),
    .dataDone     (dataDoneQ),
    .we           (ram.we),
    .state        (state)
);

/* test/memSubsystem_stimulus.txt */
// kind addr len wdata expect, all hex; kind 0 load, 1 store, 2 fetch
// kind 3 is a load raised together with a fetch from the address in the wdata column
1 00100 4 13579bdf 00000000
0 00100 4 00000000 13579bdf
1 00101 1 aaaaaa42 00000000
0 00100 4 00000000 135742df
1 00102 2 0000beef 00000000
0 00100 4 00000000 beef42df
1 00104 4 cafef00d 00000000
0 00103 1 00000000 000000be
0 00102 2 00000000 0000beef
0 00105 2 00000000 0000fef0
0 00104 1 00000000 0000000d
2 00104 4 00000000 cafef00d
2 00102 4 00000000 f00dbeef
1 00200 4 00400093 00000000
2 00200 4 00000000 00400093
3 00100 4 00000200 beef42df
1 1fffe 2 00001234 00000000
0 1fffe 2 00000000 00001234
1 00300 1 0000007f 00000000
0 00300 1 00000000 0000007f
3 00105 1 00000100 000000f0
1 00204 4 fff00113 00000000
2 00204 4 00000000 fff00113
0 00206 2 00000000 0000fff0
1 00100 4 ffffffff 00000000
0 00101 2 00000000 0000ffff
0 00100 1 00000000 000000ff
3 00204 4 00000104 fff00113

/* verilog/byteRam.sv */
`timescale 1ns/1ps

`include "memCtrl_consts.svh"

module byteRam #(
    parameter int DEPTH = `MEM_BYTES
) (
    input logic  clk,
    ramBusIf.ram ram
);

    localparam int IDX_W = $clog2(DEPTH);

    logic [7:0]       mem [DEPTH];
    logic [7:0]       rdataQ;
    logic [IDX_W-1:0] idx;

    // upper address bits wrap when the RAM is smaller than the address space
    assign idx = ram.addr[IDX_W-1:0];

    always_ff @(posedge clk) begin
        if (ram.we) begin
            mem[idx] <= ram.wdata;
        end
        rdataQ <= mem[idx];
    end

    assign ram.rdata = rdataQ;

endmodule

/* verilog/memSubsystem.sv */
`timescale 1ns/1ps

`include "memCtrl_consts.svh"

module memSubsystem (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   rdy,
    input  logic                   ioBufferFull,

    input  logic                   fetchEn,
    input  logic [`MEM_ADDR_W-1:0] fetchAddr,
    output logic                   fetchDone,
    output logic [`MEM_WORD_W-1:0] fetchInst,

    input  logic                   dataEn,
    input  memPkg::accessKind      dataKind,
    input  logic [`MEM_LEN_W-1:0]  dataLen,
    input  logic [`MEM_ADDR_W-1:0] dataAddr,
    input  logic [`MEM_WORD_W-1:0] dataWdata,
    output logic                   dataDone,
    output logic [`MEM_WORD_W-1:0] dataRdata,

    output logic                   busy
);

    memReqIf fetchBus ();
    memReqIf dataBus ();
    ramBusIf ramBus ();

    // fetch is always a four-byte read
    assign fetchBus.en    = fetchEn;
    assign fetchBus.kind  = memPkg::ACC_LOAD;
    assign fetchBus.len   = `LEN_WORD;
    assign fetchBus.addr  = fetchAddr;
    assign fetchBus.wdata = '0;
    assign fetchDone      = fetchBus.done;
    assign fetchInst      = fetchBus.rdata;

    assign dataBus.en    = dataEn;
    assign dataBus.kind  = dataKind;
    assign dataBus.len   = dataLen;
    assign dataBus.addr  = dataAddr;
    assign dataBus.wdata = dataWdata;
    assign dataDone      = dataBus.done;
    assign dataRdata     = dataBus.rdata;

    memCtrl ctrl0 (
        .clk          (clk),
        .rst          (rst),
        .rdy          (rdy),
        .ioBufferFull (ioBufferFull),
        .fetchBus     (fetchBus.ctrl),
        .dataBus      (dataBus.ctrl),
        .ram          (ramBus.ctrl),
        .busy         (busy)
    );

    byteRam ram0 (
        .clk (clk),
        .ram (ramBus.ram)
    );

endmodule
